// File: design/rv32_defs.svh
/* RV32 core global defines */

`ifndef RV32_DEFS_SVH
`define RV32_DEFS_SVH

// Data and address width
`define RV32_XLEN 32

// Architectural register count
`define RV32_NREGS 32

// Reset PC and canonical NOP (ADDI x0,x0,0)
`define RV32_PC_START 32'h0000_0000
`define RV32_NOP      32'h0000_0013

`endif

// File: design/rv32_isa_pkg.sv
/* RV32I ISA encodings */

package rv32_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        // Operand B straight through, for LUI
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // Branch conditions, ALWAYS marks JAL
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_EQ     = 2'd1,
        BR_NE     = 2'd2,
        BR_ALWAYS = 2'd3
    } br_cond_e;

endpackage

// File: design/rv32_pipe_pkg.sv
/* RV32 pipeline records */

`include "rv32_defs.svh"

package rv32_pipe_pkg;
    import rv32_isa_pkg::*;

    typedef logic [4:0] reg_idx_t;

    // IF/ID register
    typedef struct packed {
        logic [`RV32_XLEN-1:0] pc;
        logic [31:0]           ir;
    } pipe_if_id_t;

    // ID/EX register
    typedef struct packed {
        logic [`RV32_XLEN-1:0] pc;
        reg_idx_t              rs1;
        reg_idx_t              rs2;
        logic [`RV32_XLEN-1:0] rs1_data;
        logic [`RV32_XLEN-1:0] rs2_data;
        logic [`RV32_XLEN-1:0] imm;
        logic                  use_imm;
        alu_op_e               alu_op;
        br_cond_e              br_cond;
        logic                  is_jal;
        reg_idx_t              rd;
        logic                  wr_en;
    } pipe_id_ex_t;

    // Taken branch or jump from EX
    typedef struct packed {
        logic                  valid;
        logic [`RV32_XLEN-1:0] target;
    } redirect_t;

    // One retired instruction
    typedef struct packed {
        logic                  valid;
        logic [`RV32_XLEN-1:0] pc;
        reg_idx_t              rd;
        logic                  wr_en;
        logic [`RV32_XLEN-1:0] data;
    } retire_t;

endpackage

// File: design/rv32_fetch.sv
/* RV32 instruction fetch */

`include "rv32_defs.svh"

module rv32_fetch
    import rv32_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstz,
    // Instruction memory
    output logic [`RV32_XLEN-1:0] instr_addr,
    input  logic [31:0]           instr_data,
    output logic                  instr_req,
    input  logic                  instr_gnt,
    // Toward decode
    output pipe_if_id_t           fetch,
    output logic                  pipe_out_vld,
    input  logic                  pipe_out_rdy,
    // From EX and control
    input  redirect_t             redirect,
    input  logic                  flush
);

    typedef enum logic [1:0] {
        INIT,
        FETCH,
        STALL
    } state_e;

    logic [`RV32_XLEN-1:0] pc;
    logic [`RV32_XLEN-1:0] pc_last;
    logic                  update_pc;
    logic                  fetch_rdy;
    logic                  fetch_vld;
    // Stale response still in flight after a redirect
    logic                  drop;
    state_e                state, next_state;

    // ==================================================
    // PC generation
    // pc_last tags the response of the address issued last
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pc      <= `RV32_PC_START;
            pc_last <= '0;
        end else if (redirect.valid) begin
            // Target held in pc until the next issue slot
            pc <= redirect.target;
            if (update_pc) begin
                pc_last <= pc;
            end
        end else if (update_pc) begin
            pc      <= pc + `RV32_XLEN'd4;
            pc_last <= pc;
        end
    end

    assign update_pc = next_state == FETCH;

    // ==================================================
    // Fetch FSM
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) state <= INIT;
        else       state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT:    next_state = FETCH;
            FETCH:   next_state = (instr_gnt && fetch_rdy) ? FETCH : STALL;
            STALL:   if (instr_gnt && fetch_rdy) next_state = FETCH;
            default: next_state = INIT;
        endcase
    end

    // ==================================================
    // Output register
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            fetch_vld <= 1'b0;
            drop      <= 1'b0;
        end else if (flush) begin
            fetch_vld <= 1'b0;
            drop      <= 1'b1;
        end else if (instr_gnt && fetch_rdy) begin
            // First response after a redirect is wrong path
            fetch_vld <= ~drop;
            drop      <= 1'b0;
        end else if (fetch_vld && pipe_out_rdy) begin
            fetch_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_gnt && fetch_rdy && !flush && !drop) begin
            fetch <= '{pc: pc_last, ir: instr_data};
        end
    end

    // Empty or draining this cycle
    assign fetch_rdy = ~fetch_vld | pipe_out_rdy;

    // Hold the pending address while stalled
    assign instr_addr   = (next_state != FETCH) ? pc_last : pc;
    assign instr_req    = fetch_rdy;
    assign pipe_out_vld = fetch_vld;

endmodule

// File: design/rv32_decode.sv
/* RV32 instruction decode */

`include "rv32_defs.svh"

module rv32_decode
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstz,
    input  pipe_if_id_t           fetch,
    input  logic                  pipe_in_vld,
    output logic                  pipe_in_rdy,
    // Register file read
    output reg_idx_t              rs1_idx,
    output reg_idx_t              rs2_idx,
    input  logic [`RV32_XLEN-1:0] rs1_data,
    input  logic [`RV32_XLEN-1:0] rs2_data,
    input  logic                  flush,
    output pipe_id_ex_t           id_ex,
    output logic                  id_vld
);

    opcode_e     raw_opc, opc;
    logic [2:0]  raw_f3, f3;
    logic [6:0]  raw_f7;
    logic        legal;
    logic [31:0] ir;
    pipe_id_ex_t dec;

    // ==================================================
    // Legality check on the raw word
    assign raw_opc = opcode_e'(fetch.ir[6:0]);
    assign raw_f3  = fetch.ir[14:12];
    assign raw_f7  = fetch.ir[31:25];

    always_comb begin
        case (raw_opc)
            // SUB is the only funct7 variant kept
            OPC_OP:     legal = (raw_f7 == 7'b0000000 && raw_f3 != 3'b011)
                             || (raw_f7 == 7'b0100000 && raw_f3 == 3'b000);
            OPC_OP_IMM: legal = raw_f3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
            OPC_LUI,
            OPC_JAL:    legal = 1'b1;
            // BEQ and BNE only
            OPC_BRANCH: legal = raw_f3[2:1] == 2'b00;
            default:    legal = 1'b0;
        endcase
    end

    // Anything unsupported runs as NOP
    assign ir      = legal ? fetch.ir : `RV32_NOP;
    assign opc     = opcode_e'(ir[6:0]);
    assign f3      = ir[14:12];
    assign rs1_idx = ir[19:15];
    assign rs2_idx = ir[24:20];

    // ==================================================
    // Control and immediate generation
    always_comb begin
        dec          = '0;
        dec.pc       = fetch.pc;
        dec.rs1      = rs1_idx;
        dec.rs2      = rs2_idx;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.rd       = ir[11:7];
        dec.alu_op   = ALU_ADD;
        dec.br_cond  = BR_NONE;
        case (opc)
            OPC_OP: begin
                dec.wr_en = 1'b1;
                case (f3)
                    3'b000:  dec.alu_op = ir[30] ? ALU_SUB : ALU_ADD;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b101:  dec.alu_op = ALU_SRL;
                    3'b110:  dec.alu_op = ALU_OR;
                    default: dec.alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                dec.wr_en   = 1'b1;
                dec.use_imm = 1'b1;
                // I-type
                dec.imm     = {{20{ir[31]}}, ir[31:20]};
                case (f3)
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.alu_op = ALU_ADD;
                endcase
            end
            OPC_LUI: begin
                dec.wr_en   = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = ALU_PASS_B;
                // U-type
                dec.imm     = {ir[31:12], 12'b0};
            end
            OPC_JAL: begin
                dec.wr_en   = 1'b1;
                dec.is_jal  = 1'b1;
                dec.br_cond = BR_ALWAYS;
                // J-type
                dec.imm     = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                dec.br_cond = f3[0] ? BR_NE : BR_EQ;
                // B-type
                dec.imm     = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            default: ;
        endcase
    end

    // ==================================================
    // ID/EX register
    // EX never stalls, so only a flush refuses the item
    assign pipe_in_rdy = ~flush;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) id_vld <= 1'b0;
        else       id_vld <= pipe_in_vld & pipe_in_rdy;
    end

    always_ff @(posedge clk) begin
        if (pipe_in_vld && pipe_in_rdy) begin
            id_ex <= dec;
        end
    end

endmodule

// File: design/rv32_regfile.sv
/* RV32 register file */

`include "rv32_defs.svh"

module rv32_regfile
    import rv32_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstz,
    input  reg_idx_t              rs1_idx,
    input  reg_idx_t              rs2_idx,
    output logic [`RV32_XLEN-1:0] rs1_data,
    output logic [`RV32_XLEN-1:0] rs2_data,
    input  logic                  wr_en,
    input  reg_idx_t              wr_idx,
    input  logic [`RV32_XLEN-1:0] wr_data
);

    logic [`RV32_XLEN-1:0] regs [`RV32_NREGS];

    // Read with write-through of a same-cycle write
    function automatic logic [`RV32_XLEN-1:0] read_port(reg_idx_t idx);
        if (idx == '0)                   return '0;
        else if (wr_en && wr_idx == idx) return wr_data;
        else                             return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    // x0 is never written
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 0; i < `RV32_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: design/rv32_execute.sv
/* RV32 execute and writeback */

`include "rv32_defs.svh"

module rv32_execute
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstz,
    input  pipe_id_ex_t           id_ex,
    input  logic                  id_vld,
    input  logic                  fwd_a,
    input  logic                  fwd_b,
    // Register file write
    output logic                  wr_en,
    output reg_idx_t              wr_idx,
    output logic [`RV32_XLEN-1:0] wr_data,
    output redirect_t             redirect,
    output retire_t               retire
);

    logic [`RV32_XLEN-1:0] op_a, op_b_reg, op_b;
    logic [`RV32_XLEN-1:0] alu_res;
    logic [`RV32_XLEN-1:0] link;
    // Result of the previous EX write
    logic [`RV32_XLEN-1:0] res_q;
    logic                  taken;

    // ==================================================
    // Operand select
    assign op_a     = fwd_a ? res_q : id_ex.rs1_data;
    assign op_b_reg = fwd_b ? res_q : id_ex.rs2_data;
    assign op_b     = id_ex.use_imm ? id_ex.imm : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`RV32_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Branch compare on register operands only
    always_comb begin
        case (id_ex.br_cond)
            BR_EQ:     taken = op_a == op_b_reg;
            BR_NE:     taken = op_a != op_b_reg;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // ==================================================
    // Writeback and redirect
    assign link     = id_ex.pc + `RV32_XLEN'd4;
    assign wr_en    = id_vld & id_ex.wr_en;
    assign wr_idx   = id_ex.rd;
    assign wr_data  = id_ex.is_jal ? link : alu_res;
    assign redirect = '{valid: id_vld & taken, target: id_ex.pc + id_ex.imm};

    always_ff @(posedge clk) begin
        if (wr_en) res_q <= wr_data;
    end

    // Retire port, one cycle after EX
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            retire <= '0;
        end else begin
            retire <= '{valid: id_vld, pc: id_ex.pc, rd: id_ex.rd,
                        wr_en: id_ex.wr_en, data: wr_data};
        end
    end

endmodule

// File: design/rv32_pipe_ctrl.sv
/* RV32 pipeline control */

module rv32_pipe_ctrl
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rstz,
    input  redirect_t   redirect,
    input  pipe_id_ex_t id_ex,
    input  logic        id_vld,
    // Current EX write
    input  logic        wr_en,
    input  reg_idx_t    wr_idx,
    output logic        flush,
    output logic        fwd_a,
    output logic        fwd_b
);

    logic     prev_wr_en;
    reg_idx_t prev_wr_idx;
    logic     reads_rs1, reads_rs2;

    // Previous cycle's EX write, cleared by bubbles
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            prev_wr_en  <= 1'b0;
            prev_wr_idx <= '0;
        end else begin
            prev_wr_en  <= wr_en;
            prev_wr_idx <= wr_idx;
        end
    end

    // LUI and JAL ignore rs1, immediates ignore rs2
    assign reads_rs1 = !id_ex.is_jal && id_ex.alu_op != ALU_PASS_B;
    assign reads_rs2 = !id_ex.use_imm;

    // x0 never forwards
    assign fwd_a = id_vld && reads_rs1 && prev_wr_en
                && prev_wr_idx != '0 && prev_wr_idx == id_ex.rs1;
    assign fwd_b = id_vld && reads_rs2 && prev_wr_en
                && prev_wr_idx != '0 && prev_wr_idx == id_ex.rs2;

    // Kill the wrong path in fetch and decode
    assign flush = redirect.valid;

endmodule

// File: design/rv32_core.sv
/* RV32 core top */

`include "rv32_defs.svh"

module rv32_core
    import rv32_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstz,
    output logic [`RV32_XLEN-1:0] instr_addr,
    output logic                  instr_req,
    input  logic [31:0]           instr_data,
    input  logic                  instr_gnt,
    output retire_t               retire
);

    // ==================================================
    // Stage interconnect
    pipe_if_id_t           fetch;
    logic                  if_vld, if_rdy;
    pipe_id_ex_t           id_ex;
    logic                  id_vld;
    reg_idx_t              rs1_idx, rs2_idx;
    logic [`RV32_XLEN-1:0] rs1_data, rs2_data;
    logic                  wr_en;
    reg_idx_t              wr_idx;
    logic [`RV32_XLEN-1:0] wr_data;
    redirect_t             redirect;
    logic                  flush, fwd_a, fwd_b;

    rv32_fetch u_fetch (
        .clk, .rstz,
        .instr_addr, .instr_data, .instr_req, .instr_gnt,
        .fetch, .pipe_out_vld(if_vld), .pipe_out_rdy(if_rdy),
        .redirect, .flush
    );

    rv32_decode u_decode (
        .clk, .rstz,
        .fetch, .pipe_in_vld(if_vld), .pipe_in_rdy(if_rdy),
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .flush, .id_ex, .id_vld
    );

    rv32_regfile u_regfile (
        .clk, .rstz,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .wr_en, .wr_idx, .wr_data
    );

    rv32_execute u_execute (
        .clk, .rstz,
        .id_ex, .id_vld, .fwd_a, .fwd_b,
        .wr_en, .wr_idx, .wr_data,
        .redirect, .retire
    );

    rv32_pipe_ctrl u_pipe_ctrl (
        .clk, .rstz,
        .redirect, .id_ex, .id_vld,
        .wr_en, .wr_idx,
        .flush, .fwd_a, .fwd_b
    );

endmodule

// File: testbench/rv32_core_chk.sv
/* RV32 core pipe assertions */

module rv32_core_chk
    import rv32_pipe_pkg::*;
(
    input logic        clk,
    input logic        rstz,
    input redirect_t   redirect,
    input logic        flush,
    input retire_t     retire,
    input pipe_if_id_t fetch,
    input logic        if_vld,
    input logic        if_rdy,
    input logic        id_vld
);

    timeunit 1ns;
    timeprecision 100ps;

    // ==================================================
    // Control
    // A taken branch or jump kills the wrong path and the stale response
    a_redirect_flush: assert property (
        @(posedge clk) disable iff (!rstz)
        redirect.valid |-> flush ##1 (!if_vld && !id_vld) ##1 (!if_vld && !id_vld)
    ) else $error("redirect did not flush the wrong path");

    // Retire port
    // Whole record known whenever it is valid
    a_retire_known: assert property (
        @(posedge clk) disable iff (!rstz)
        !$isunknown(retire.valid) && (!retire.valid || !$isunknown(retire))
    ) else $error("retire record unknown after reset");

    // Fetch to decode pipe holds its item while refused
    a_fetch_stable: assert property (
        @(posedge clk) disable iff (!rstz)
        if_vld && !if_rdy |=> $stable(fetch)
    ) else $error("fetch output changed while stalled");

endmodule

bind rv32_core rv32_core_chk chk (
    .clk, .rstz, .redirect, .flush, .retire, .fetch, .if_vld, .if_rdy, .id_vld
);

// File: testbench/rv32_core_tb.sv
/* RV32 core testbench */

`include "rv32_defs.svh"

module rv32_core_tb
    import rv32_isa_pkg::*;
    import rv32_pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TESTS      = 8;
    localparam int PROG_WORDS   = 64;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_PERIOD   = 4;
    // Instruction kinds of the program generator
    localparam int K_OP  = 0;
    localparam int K_IMM = 1;
    localparam int K_LUI = 2;
    localparam int K_JAL = 3;
    localparam int K_BR  = 4;

    logic                  clk;
    logic                  rstz;
    logic [`RV32_XLEN-1:0] instr_addr;
    logic                  instr_req;
    logic [31:0]           instr_data;
    logic                  instr_gnt;
    retire_t               retire;

    // Program image and its descriptors
    logic [31:0] rom [PROG_WORDS];
    int          kind [PROG_WORDS];
    int          sel [PROG_WORDS];
    reg_idx_t    rd [PROG_WORDS];
    reg_idx_t    rs1 [PROG_WORDS];
    reg_idx_t    rs2 [PROG_WORDS];
    logic [31:0] imm [PROG_WORDS];

    // Expected retire sequence from the ISA model
    logic [31:0] exp_pc [$];
    reg_idx_t    exp_rd [$];
    bit          exp_wr [$];
    logic [31:0] exp_data [$];

    logic [31:0] lfsr;
    logic [31:0] last_addr;
    int          n_errors;
    int          n_checks;

    rv32_core dut (
        .clk, .rstz, .instr_addr, .instr_req, .instr_data, .instr_gnt, .retire
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Memory answers with the word of the previously accepted address
    always @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            last_addr <= '0;
        end else if (instr_req && instr_gnt) begin
            last_addr <= instr_addr;
        end
    end

    // ==================================================
    // Random source and encoders
    // Taps 32, 22, 2, 1
    function logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    // {funct7, funct3} of the register ops
    function logic [9:0] op_funct(int s);
        case (s)
            0:       return {7'h00, 3'b000};
            1:       return {7'h20, 3'b000};
            2:       return {7'h00, 3'b111};
            3:       return {7'h00, 3'b110};
            4:       return {7'h00, 3'b100};
            5:       return {7'h00, 3'b010};
            6:       return {7'h00, 3'b001};
            default: return {7'h00, 3'b101};
        endcase
    endfunction

    // ADDI ANDI ORI XORI SLTI as register-op selectors
    function int imm_sel(int s);
        case (s)
            0:       return 0;
            1:       return 2;
            2:       return 3;
            3:       return 4;
            default: return 5;
        endcase
    endfunction

    function logic [2:0] imm_f3(int s);
        logic [9:0] f;
        f = op_funct(imm_sel(s));
        return f[2:0];
    endfunction

    function logic [31:0] encode(int k, int s, reg_idx_t d, reg_idx_t a,
                                 reg_idx_t b, logic [31:0] v);
        logic [9:0] f;
        f = op_funct(s);
        case (k)
            K_OP:    return {f[9:3], b, a, f[2:0], d, OPC_OP};
            K_IMM:   return {v[11:0], a, imm_f3(s), d, OPC_OP_IMM};
            K_LUI:   return {v[31:12], d, OPC_LUI};
            K_JAL:   return {v[20], v[10:1], v[11], v[19:12], d, OPC_JAL};
            default: return {v[12], v[10:5], b, a, 2'b00, s[0], v[4:1], v[11], OPC_BRANCH};
        endcase
    endfunction

    function logic [31:0] rom_word(logic [31:0] addr);
        if (addr < PROG_WORDS * 4) return rom[addr[7:2]];
        else                       return `RV32_NOP;
    endfunction

    // ==================================================
    // Program generator and ISA model
    // Only forward targets, so every program falls off into NOPs
    function void gen_program(bit br_en, int reg_bits);
        logic [31:0] r;
        logic [31:0] v;
        int          k;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r = rand_bits(3);
            if (br_en && r == 0)      kind[i] = K_JAL;
            else if (br_en && r < 3)  kind[i] = K_BR;
            else if (r == 3)          kind[i] = K_LUI;
            else if (r == 4 || r == 5) kind[i] = K_IMM;
            else                      kind[i] = K_OP;
            rd[i]  = reg_idx_t'(rand_bits(reg_bits));
            rs1[i] = reg_idx_t'(rand_bits(reg_bits));
            rs2[i] = reg_idx_t'(rand_bits(reg_bits));
            sel[i] = int'(rand_bits(3));
            case (kind[i])
                K_IMM: begin
                    sel[i] = sel[i] % 5;
                    v      = rand_bits(12);
                    imm[i] = {{20{v[11]}}, v[11:0]};
                end
                K_LUI: imm[i] = rand_bits(20) << 12;
                K_OP:  imm[i] = '0;
                default: begin
                    sel[i] = sel[i] % 2;
                    k      = int'(rand_bits(3)) + 1;
                    if (i + k > PROG_WORDS) k = PROG_WORDS - i;
                    imm[i] = 32'(k * 4);
                end
            endcase
            rom[i] = encode(kind[i], sel[i], rd[i], rs1[i], rs2[i], imm[i]);
        end
    endfunction

    // Register op semantics
    function logic [31:0] model_alu(int s, logic [31:0] a, logic [31:0] b);
        case (s)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    function void run_model();
        logic [31:0] regs [32];
        logic [31:0] pc, nxt, a, b, res;
        bit          wr;
        int          i;
        exp_pc.delete();
        exp_rd.delete();
        exp_wr.delete();
        exp_data.delete();
        foreach (regs[j]) regs[j] = '0;
        pc = `RV32_PC_START;
        while (pc < PROG_WORDS * 4) begin
            i   = int'(pc >> 2);
            a   = regs[rs1[i]];
            b   = regs[rs2[i]];
            nxt = pc + 4;
            wr  = 1'b1;
            res = '0;
            case (kind[i])
                K_OP:  res = model_alu(sel[i], a, b);
                K_IMM: res = model_alu(imm_sel(sel[i]), a, imm[i]);
                K_LUI: res = imm[i];
                K_JAL: begin
                    res = pc + 4;
                    nxt = pc + imm[i];
                end
                default: begin
                    wr = 1'b0;
                    // BEQ when sel is 0, BNE otherwise
                    if ((a == b) == (sel[i] == 0)) nxt = pc + imm[i];
                end
            endcase
            // x0 keeps zero, the record still carries the result
            if (wr && rd[i] != 0) regs[rd[i]] = res;
            exp_pc.push_back(pc);
            exp_rd.push_back(rd[i]);
            exp_wr.push_back(wr);
            exp_data.push_back(res);
            pc = nxt;
        end
    endfunction

    // ==================================================
    // Compare tasks
    task automatic check_pc(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_data(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ==================================================
    // One test: new program, reset, collect all retirements
    task automatic run_test(int t, string name, bit br_en, int reg_bits, bit gnt_rand);
        int got;
        int errs_before;
        gen_program(br_en, reg_bits);
        run_model();
        errs_before = n_errors;
        @(negedge clk);
        rstz      = 1'b0;
        instr_gnt = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        // First cycle after reset runs with the grant low
        rstz = 1'b1;
        got  = 0;
        while (got < exp_pc.size()) begin
            @(negedge clk);
            instr_data = rom_word(last_addr);
            instr_gnt  = gnt_rand ? (rand_bits(2) != 0) : 1'b1;
            if (retire.valid) begin
                check_pc("retire.pc", retire.pc, exp_pc[got]);
                check_data("retire.wr_en", 32'(retire.wr_en), 32'(exp_wr[got]));
                if (exp_wr[got]) begin
                    check_reg("retire.rd", retire.rd, exp_rd[got]);
                    check_data("retire.data", retire.data, exp_data[got]);
                end
                got++;
            end
        end
        $display("test %0d %s: %0d retired, %0d errors", t, name, got,
                 n_errors - errs_before);
    endtask

    // Watchdog sized from the test lengths
    initial begin
        #(N_TESTS * PROG_WORDS * 8 * CLK_PERIOD);
        $display("Timeout: the core stopped retiring before the tests completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rstz       = 1'b0;
        instr_gnt  = 1'b0;
        instr_data = `RV32_NOP;
        lfsr       = 32'd68278;
        n_errors   = 0;
        n_checks   = 0;
        // Small register sets make dependencies and equal operands likely
        run_test(0, "alu straight", 1'b0, 3, 1'b0);
        run_test(1, "alu dependent", 1'b0, 2, 1'b0);
        run_test(2, "branches", 1'b1, 3, 1'b0);
        run_test(3, "branches dependent", 1'b1, 2, 1'b0);
        run_test(4, "alu stalls", 1'b0, 3, 1'b1);
        run_test(5, "branches stalls", 1'b1, 2, 1'b1);
        run_test(6, "mix stalls", 1'b1, 3, 1'b1);
        run_test(7, "mix stalls dependent", 1'b1, 2, 1'b1);
        $display("%0d tests, %0d checks, %0d errors", N_TESTS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/rv32_isa_pkg.sv
design/rv32_pipe_pkg.sv
design/rv32_fetch.sv
design/rv32_decode.sv
design/rv32_regfile.sv
design/rv32_execute.sv
design/rv32_pipe_ctrl.sv
design/rv32_core.sv
testbench/rv32_core_chk.sv
testbench/rv32_core_tb.sv

// File: Makefile
# Verilator build for the RV32 core testbench

VERILATOR ?= verilator
TOP       ?= rv32_core_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then exit 1; fi
	@if ! grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
